/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= countdown_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
PASS_MSG  := SIMULATION PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* flist.f */
src/countdown_pkg.sv
src/second_tick.sv
src/countdown_ctrl.sv
src/matrix_scan.sv
src/countdown_top.sv
verification/countdown_tb.sv

/* src/countdown_ctrl.sv */
`default_nettype none

module countdown_ctrl (
    input  wire                               clk,
    input  wire                               rst,
    input  wire                               start,
    input  wire                               tick,
    output logic                              restart,
    output logic [countdown_pkg::DIGIT_W-1:0] digit,
    output logic                              done
);
    import countdown_pkg::*;

    logic counting;

    // blank and zero both hold still
    assign counting = (digit != '0) && (digit != DIGIT_W'(BLANK_CODE));

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            restart <= 1'b0;
        else
            restart <= start; // realigns the second divider
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            digit <= DIGIT_W'(BLANK_CODE);
        end
        else if (start)
        begin
            digit <= DIGIT_W'(START_DIGIT); // reload even mid count
        end
        else if (tick && counting)
        begin
            digit <= digit - 1'b1;
        end
    end

    // one clock pulse on the step from 1 to 0
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            done <= 1'b0;
        else
            done <= !start && tick && (digit == DIGIT_W'(1));
    end

endmodule

`default_nettype wire

/* src/countdown_pkg.sv */
`default_nettype none

package countdown_pkg;

    // matrix geometry, rows and columns alike
    localparam int MATRIX_SIZE = 8;
    localparam int ROW_IDX_W   = 3;

    // digit codes 0..6 are drawn
    localparam int DIGIT_W     = 3;
    localparam int START_DIGIT = 6;

    // code shown after reset, lights nothing
    localparam int BLANK_CODE  = 7;

    // scan clock is 1 kHz
    localparam int TICKS_PER_SEC = 1000;
    localparam int TICK_CNT_W    = 10;

endpackage

`default_nettype wire

/* src/countdown_top.sv */
`default_nettype none

module countdown_top (
    input  wire                                   clk,
    input  wire                                   rst,
    input  wire                                   start,
    output logic [countdown_pkg::MATRIX_SIZE-1:0] row,
    output logic [countdown_pkg::MATRIX_SIZE-1:0] colr,
    output logic [countdown_pkg::MATRIX_SIZE-1:0] colg,
    output logic                                  done
);
    import countdown_pkg::*;

    logic               restart;
    logic               tick;
    logic [DIGIT_W-1:0] digit;

    // free running, realigned by restart
    second_tick u_tick (
        .clk     (clk),
        .rst     (rst),
        .restart (restart),
        .tick    (tick)
    );

    countdown_ctrl u_ctrl (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .tick    (tick),
        .restart (restart),
        .digit   (digit),
        .done    (done)
    );

    // display lags digit by two clocks
    matrix_scan u_scan (
        .clk   (clk),
        .rst   (rst),
        .digit (digit),
        .row   (row),
        .colr  (colr),
        .colg  (colg)
    );

endmodule

`default_nettype wire

/* src/matrix_scan.sv */
`default_nettype none

module matrix_scan (
    input  wire                                   clk,
    input  wire                                   rst,
    input  wire  [countdown_pkg::DIGIT_W-1:0]     digit,
    output logic [countdown_pkg::MATRIX_SIZE-1:0] row,
    output logic [countdown_pkg::MATRIX_SIZE-1:0] colr,
    output logic [countdown_pkg::MATRIX_SIZE-1:0] colg
);
    import countdown_pkg::*;

    logic [DIGIT_W-1:0]     dig_q;
    logic [ROW_IDX_W-1:0]   row_idx;
    logic [MATRIX_SIZE-1:0] glyph;
    logic                   red_on;
    logic                   green_on;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            dig_q <= DIGIT_W'(BLANK_CODE);
        else
            dig_q <= digit;
    end

    // one row per clock, wraps after row 7
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            row_idx <= '0;
        else
            row_idx <= row_idx + 1'b1;
    end

    // glyphs sit in rows 1..7, row 0 stays dark
    always_comb
    begin
        glyph = '0;
        case (dig_q)
            3'd6:
                case (row_idx)
                    3'd1, 3'd7:       glyph = 8'b0011_1100;
                    3'd2:             glyph = 8'b0110_0000;
                    3'd3:             glyph = 8'b0111_1100;
                    3'd4, 3'd5, 3'd6: glyph = 8'b0110_0110;
                    default:          glyph = '0;
                endcase
            3'd5:
                case (row_idx)
                    3'd1:       glyph = 8'b0111_1110;
                    3'd2:       glyph = 8'b0110_0000;
                    3'd3:       glyph = 8'b0111_1100;
                    3'd4, 3'd5: glyph = 8'b0000_0110;
                    3'd6:       glyph = 8'b0110_0110;
                    3'd7:       glyph = 8'b0011_1100;
                    default:    glyph = '0;
                endcase
            3'd4:
                case (row_idx)
                    3'd1, 3'd6, 3'd7: glyph = 8'b0000_1100;
                    3'd2:             glyph = 8'b0001_1100;
                    3'd3:             glyph = 8'b0010_1100;
                    3'd4:             glyph = 8'b0100_1100;
                    3'd5:             glyph = 8'b0111_1110;
                    default:          glyph = '0;
                endcase
            3'd3:
                case (row_idx)
                    3'd1, 3'd7: glyph = 8'b0011_1100;
                    3'd2, 3'd6: glyph = 8'b0110_0110;
                    3'd3, 3'd5: glyph = 8'b0000_0110;
                    3'd4:       glyph = 8'b0001_1100;
                    default:    glyph = '0;
                endcase
            3'd2:
                case (row_idx)
                    3'd1:    glyph = 8'b0011_1100;
                    3'd2:    glyph = 8'b0110_0110;
                    3'd3:    glyph = 8'b0000_0110;
                    3'd4:    glyph = 8'b0000_1100;
                    3'd5:    glyph = 8'b0011_0000;
                    3'd6:    glyph = 8'b0110_0000;
                    3'd7:    glyph = 8'b0111_1110;
                    default: glyph = '0;
                endcase
            3'd1:
                case (row_idx)
                    3'd1, 3'd2, 3'd4, 3'd5, 3'd6: glyph = 8'b0001_1000;
                    3'd3:                         glyph = 8'b0011_1000;
                    3'd7:                         glyph = 8'b0111_1110;
                    default:                      glyph = '0;
                endcase
            3'd0:
                case (row_idx)
                    3'd1, 3'd7:                   glyph = 8'b0011_1100;
                    3'd2, 3'd3, 3'd4, 3'd5, 3'd6: glyph = 8'b0100_0010;
                    default:                      glyph = '0;
                endcase
            default:
                glyph = '0; // blank code
        endcase
    end

    // colour groups, yellow is both
    always_comb
    begin
        case (dig_q)
            3'd4, 3'd5, 3'd6:
            begin
                red_on   = 1'b1;
                green_on = 1'b0;
            end
            3'd2, 3'd3:
            begin
                red_on   = 1'b1;
                green_on = 1'b1;
            end
            3'd0, 3'd1:
            begin
                red_on   = 1'b0;
                green_on = 1'b1;
            end
            default:
            begin
                red_on   = 1'b0;
                green_on = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row  <= '1;
            colr <= '0;
            colg <= '0;
        end
        else
        begin
            row  <= ~(MATRIX_SIZE'(1) << row_idx); // active low select
            colr <= red_on ? glyph : '0;
            colg <= green_on ? glyph : '0;
        end
    end

endmodule

`default_nettype wire

/* src/second_tick.sv */
`default_nettype none

module second_tick (
    input  wire  clk,
    input  wire  rst,
    input  wire  restart,
    output logic tick
);
    import countdown_pkg::*;

    logic [TICK_CNT_W-1:0] cnt;

    // strobe on the last clock of each second
    // held off while restart realigns the count
    assign tick = (cnt == TICK_CNT_W'(TICKS_PER_SEC - 1)) && !restart;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            cnt <= '0;
        else if (restart)
            cnt <= TICK_CNT_W'(1); // restart lands one clock after start
        else if (tick)
            cnt <= '0;
        else
            cnt <= cnt + 1'b1;
    end

endmodule

`default_nettype wire

/* verification/countdown_patterns.txt */
// each line is {colr, colg} as one 16-bit hex word, red in the upper byte
// eight lines per digit code 0 to 7, rows 0 to 7 in order
0000
003c
0042
0042
0042
0042
0042
003c
0000
0018
0018
0038
0018
0018
0018
007e
0000
3c3c
6666
0606
0c0c
3030
6060
7e7e
0000
3c3c
6666
0606
1c1c
0606
6666
3c3c
0000
0c00
1c00
2c00
4c00
7e00
0c00
0c00
0000
7e00
6000
7c00
0600
0600
6600
3c00
0000
3c00
6000
7c00
6600
6600
6600
3c00
0000
0000
0000
0000
0000
0000
0000
0000

/* verification/countdown_tb.sv */
`default_nettype none

module countdown_tb;
    import countdown_pkg::*;

    localparam int CYCLE_LIMIT = 16 + 3 * (START_DIGIT + 1) * TICKS_PER_SEC + 200;
    localparam int PAT_DEPTH   = (BLANK_CODE + 1) * MATRIX_SIZE;

    logic                   clk;
    logic                   rst;
    logic                   start;
    logic [MATRIX_SIZE-1:0] row;
    logic [MATRIX_SIZE-1:0] colr;
    logic [MATRIX_SIZE-1:0] colg;
    logic                   done;

    // {red, green} per digit code and row
    logic [2*MATRIX_SIZE-1:0] pat_mem [0:PAT_DEPTH-1];
    logic [MATRIX_SIZE-1:0]   red_tab [0:BLANK_CODE][0:MATRIX_SIZE-1];
    logic [MATRIX_SIZE-1:0]   green_tab [0:BLANK_CODE][0:MATRIX_SIZE-1];

    int                 cyc;          // rising edges since reset release
    int                 timeout_cnt;
    int                 s_edge;       // edge where the latest start was sampled
    bit                 have_start;
    logic [DIGIT_W-1:0] exp_digit;
    int                 skip;
    int                 mid;
    int                 row_errs;
    int                 col_errs;
    int                 done_errs;

    countdown_top dut0 (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .row   (row),
        .colr  (colr),
        .colg  (colg),
        .done  (done)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial
    begin
        timeout_cnt = 0;
        while (timeout_cnt < CYCLE_LIMIT)
        begin
            @(posedge clk);
            timeout_cnt++;
        end
        $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        print_error_counts();
        $display("SIMULATION FAILED");
        $finish;
    end

    // one step down per second from the start edge until zero
    function automatic logic [DIGIT_W-1:0] digit_for_edge(input int n);
        int secs;
        if (!have_start || n < s_edge)
            return DIGIT_W'(BLANK_CODE);
        secs = (n - s_edge) / TICKS_PER_SEC;
        if (secs >= START_DIGIT)
            return '0;
        return DIGIT_W'(START_DIGIT - secs);
    endfunction

    task automatic check_row(input logic [MATRIX_SIZE-1:0] exp_row,
                             input logic [MATRIX_SIZE-1:0] act_row);
        if (act_row !== exp_row)
        begin
            $display("Fail at %0t: row expected %b, got %b", $time, exp_row, act_row);
            row_errs++;
        end
    endtask

    task automatic check_cols(input logic [MATRIX_SIZE-1:0] exp_r,
                              input logic [MATRIX_SIZE-1:0] exp_g,
                              input logic [MATRIX_SIZE-1:0] act_r,
                              input logic [MATRIX_SIZE-1:0] act_g);
        if (act_r !== exp_r)
        begin
            $display("Fail at %0t: colr expected %h, got %h", $time, exp_r, act_r);
            col_errs++;
        end
        if (act_g !== exp_g)
        begin
            $display("Fail at %0t: colg expected %h, got %h", $time, exp_g, act_g);
            col_errs++;
        end
    endtask

    task automatic check_done(input logic exp_done, input logic act_done);
        if (act_done !== exp_done)
        begin
            $display("Fail at %0t: done expected %b, got %b", $time, exp_done, act_done);
            done_errs++;
        end
    endtask

    task automatic load_patterns;
        $readmemh("verification/countdown_patterns.txt", pat_mem);
        for (int d = 0; d <= BLANK_CODE; d++)
        begin
            for (int r = 0; r < MATRIX_SIZE; r++)
            begin
                red_tab[d][r]   = pat_mem[d*MATRIX_SIZE + r][2*MATRIX_SIZE-1:MATRIX_SIZE];
                green_tab[d][r] = pat_mem[d*MATRIX_SIZE + r][MATRIX_SIZE-1:0];
            end
        end
    endtask

    // all checks happen at the falling edge
    task automatic run_cycles(input int n);
        logic [DIGIT_W-1:0]     d;
        int                     ridx;
        logic [MATRIX_SIZE-1:0] exp_row;
        repeat (n)
        begin
            @(negedge clk);
            start = 1'b0;
            cyc++;
            d = digit_for_edge(cyc);
            if (d != exp_digit)
            begin
                exp_digit = d;
                skip = 2; // display lags by two clocks
            end
            ridx = (cyc - 1) % MATRIX_SIZE;
            exp_row = '1;
            exp_row[ridx] = 1'b0; // only the shown row is low
            check_row(exp_row, row);
            if (skip > 0)
                skip--;
            else
                check_cols(red_tab[exp_digit][ridx], green_tab[exp_digit][ridx], colr, colg);
            check_done(have_start && (cyc == s_edge + START_DIGIT * TICKS_PER_SEC), done);
        end
    endtask

    task automatic pulse_start;
        start = 1'b1;
        have_start = 1'b1;
        s_edge = cyc + 1; // sampled at the next rising edge
    endtask

    task automatic wait_for_done;
        run_cycles(1);
        while (done !== 1'b1)
            run_cycles(1);
    endtask

    task automatic print_error_counts;
        $display("errors: row %0d, columns %0d, done %0d", row_errs, col_errs, done_errs);
    endtask

    initial
    begin
        rst        = 1'b1;
        start      = 1'b0;
        cyc        = 0;
        s_edge     = 0;
        have_start = 1'b0;
        exp_digit  = DIGIT_W'(BLANK_CODE);
        skip       = 0;
        row_errs   = 0;
        col_errs   = 0;
        done_errs  = 0;
        void'($urandom(32'h945d_8d61));
        load_patterns();

        repeat (16) @(negedge clk);
        rst = 1'b0;

        run_cycles(TICKS_PER_SEC + 100); // dark matrix across the first tick

        pulse_start();
        // restart point well inside a second
        mid = TICKS_PER_SEC * (1 + int'($urandom % 2)) + 100 + int'($urandom % 800);
        run_cycles(mid);
        pulse_start();
        wait_for_done();
        run_cycles(2 * TICKS_PER_SEC + 100); // stays at 0

        pulse_start(); // fresh count from zero
        wait_for_done();
        run_cycles(2 * TICKS_PER_SEC + 100);

        print_error_counts();
        if (row_errs + col_errs + done_errs == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire
